/* verilog/sram_fifo_params.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM FIFO build constants: ring depth, SRAM address width and the
// default near-full / near-empty thresholds in percent
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SRAM_FIFO_PARAMS_SVH
`define SRAM_FIFO_PARAMS_SVH

// half-words in the ring, kept small so full is reached quickly
`define SRAM_FIFO_DEPTH 64

// external SRAM address bus
`define SRAM_ADDR_W 20

// thresholds in percent, scaled to 1/256 steps in the register block
`define SRAM_FULL_PCT_DEF 95
`define SRAM_EMPTY_PCT_DEF 5

`endif

/* verilog/sram_fifo_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM FIFO types: register bus request, SRAM request and fill level view
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "sram_fifo_params.svh"

package sram_fifo_pkg;

    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;          // write data
        logic        rd;
        logic        wr;
    } bus_req_t;

    typedef struct packed {
        sram_addr_t  addr;
        logic [15:0] data;          // write data
        logic        we;            // level, one half-word per cycle
        logic        oe;
    } sram_req_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] mid;
        logic [7:0] lo;
    } size_bytes_t;

    // fill level, compared as a count or read back byte by byte
    typedef union packed {
        logic [23:0] count;
        size_bytes_t bytes;
    } fifo_size_u;

endpackage

/* verilog/sram_fifo_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM FIFO register block: soft reset, thresholds with near-full
// hysteresis, fill level readback and read error counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_fifo_params.svh"

module sram_fifo_regs
    import sram_fifo_pkg::*;
(
    input  logic       BUS_CLK,
    input  logic       RST,
    input  bus_req_t   bus,
    output logic [7:0] bus_data_out,
    input  fifo_size_u fifo_size,
    input  logic       read_error,
    output logic       fifo_rst,
    output logic       fifo_near_full,
    output logic       fifo_read_error
);

    localparam logic [7:0] FULL_THR_DEF  = 8'(`SRAM_FULL_PCT_DEF * 255 / 100);
    localparam logic [7:0] EMPTY_THR_DEF = 8'(`SRAM_EMPTY_PCT_DEF * 255 / 100);
    localparam logic [23:0] DEPTH_W      = 24'(`SRAM_FIFO_DEPTH);

    logic [7:0]  full_thr;
    logic [7:0]  empty_thr;
    logic [7:0]  err_cnt;
    logic [23:0] full_lvl;
    logic [23:0] empty_lvl;

    assign fifo_rst = RST | (bus.wr && bus.addr == 16'd0); // address 0 is soft reset

    // thresholds at 1 and 2, soft reset restores the defaults too
    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst) begin
            full_thr  <= FULL_THR_DEF;
            empty_thr <= EMPTY_THR_DEF;
        end else if (bus.wr) begin
            if (bus.addr == 16'd1)
                full_thr <= bus.data;
            if (bus.addr == 16'd2)
                empty_thr <= bus.data;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus.rd) begin
            case (bus.addr)
                16'd1:   bus_data_out <= fifo_size.bytes.hi;
                16'd2:   bus_data_out <= fifo_size.bytes.mid;
                16'd3:   bus_data_out <= fifo_size.bytes.lo;
                16'd4:   bus_data_out <= err_cnt;
                default: bus_data_out <= 8'h00;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            err_cnt <= 8'h00;
        else if (read_error && err_cnt != 8'hff)
            err_cnt <= err_cnt + 8'h01; // saturates
    end

    assign fifo_read_error = (err_cnt != 8'h00);

    // levels in half-words, thresholds are fractions of 256
    assign full_lvl  = ((24'(full_thr) + 24'd1) * DEPTH_W) >> 8;
    assign empty_lvl = ((24'(empty_thr) + 24'd1) * DEPTH_W) >> 8;

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            fifo_near_full <= 1'b0;
        else if (fifo_size.count >= full_lvl)
            fifo_near_full <= 1'b1;
        else if (fifo_size.count <= empty_lvl || fifo_size.count == 24'd0)
            fifo_near_full <= 1'b0;
    end

endmodule

/* verilog/sram_fifo_ptrs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM FIFO pointers: write sequencing of 32-bit source words as two
// half-words, ring pointers, full and empty flags and fill level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_fifo_params.svh"

module sram_fifo_ptrs
    import sram_fifo_pkg::*;
(
    input  logic       BUS_CLK,
    input  logic       fifo_rst,
    input  logic       fifo_empty_in,
    input  logic       rd_grant,
    output logic       wr_req,
    output sram_addr_t wr_addr,
    output sram_addr_t rd_addr,
    output logic       wr_half,
    output logic       fifo_read_next,
    output logic       empty,
    output logic       fifo_full,
    output fifo_size_u fifo_size
);

    localparam sram_addr_t DEPTH_A = sram_addr_t'(`SRAM_FIFO_DEPTH);
    localparam sram_addr_t LAST_A  = sram_addr_t'(`SRAM_FIFO_DEPTH - 1);

    sram_addr_t wr_ptr;
    sram_addr_t rd_ptr;
    sram_addr_t wr_ptr_nxt;
    sram_addr_t rd_ptr_nxt;
    sram_addr_t fill;
    logic       wr_go;

    always_comb begin
        if (wr_ptr == LAST_A)
            wr_ptr_nxt = '0;
        else
            wr_ptr_nxt = wr_ptr + 1'b1;

        if (rd_ptr == LAST_A)
            rd_ptr_nxt = '0;
        else
            rd_ptr_nxt = rd_ptr + 1'b1;
    end

    assign empty     = (wr_ptr == rd_ptr);
    assign fifo_full = (wr_ptr_nxt == rd_ptr); // one slot stays free

    assign wr_req  = !fifo_empty_in && !fifo_full;
    assign wr_go   = wr_req && !rd_grant;  // reads win the SRAM
    assign wr_half = wr_ptr[0];            // 0 = high half

    // source word done once its low half is stored
    assign fifo_read_next = wr_go && wr_ptr[0];

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            wr_ptr <= '0;
        else if (wr_go)
            wr_ptr <= wr_ptr_nxt;
    end

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            rd_ptr <= '0;
        else if (rd_grant)
            rd_ptr <= rd_ptr_nxt;
    end

    assign wr_addr = wr_ptr;
    assign rd_addr = rd_ptr;

    always_comb begin
        if (wr_ptr >= rd_ptr)
            fill = wr_ptr - rd_ptr;
        else
            fill = wr_ptr + (DEPTH_A - rd_ptr); // wrapped
    end

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            fifo_size.count <= 24'd0;
        else
            fifo_size.count <= 24'(fill);
    end

endmodule

/* verilog/sram_fifo_reader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM FIFO reader: fetches half-words from SRAM and hands them to the
// consumer as bytes, high byte first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sram_fifo_reader (
    input  logic        BUS_CLK,
    input  logic        fifo_rst,
    input  logic        empty,
    input  logic [15:0] sram_data_in,
    input  logic        usb_read,
    output logic        rd_grant,
    output logic [7:0]  usb_data,
    output logic        usb_valid,
    output logic        read_error
);

    typedef enum logic [1:0] {
        RD_TRY  = 2'd0,
        RD_READ = 2'd1,
        RD_HOLD = 2'd2
    } rd_state_t;

    rd_state_t   state;
    rd_state_t   state_nxt;
    logic [15:0] data_q;
    logic        byte_sel;     // 1 once the high byte is gone
    logic        last_byte;

    assign last_byte = usb_read && byte_sel;

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            state <= RD_TRY;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RD_TRY:
                if (!empty)
                    state_nxt = RD_READ;
            RD_READ:
                state_nxt = RD_HOLD;
            RD_HOLD:
                if (last_byte)
                    state_nxt = empty ? RD_TRY : RD_READ; // skip try when data waits
            default:
                state_nxt = RD_TRY;
        endcase
    end

    assign rd_grant  = (state == RD_READ);
    assign usb_valid = (state == RD_HOLD);

    always_ff @(posedge BUS_CLK) begin
        if (rd_grant)
            data_q <= sram_data_in; // sram output is combinational
    end

    always_ff @(posedge BUS_CLK) begin
        if (fifo_rst)
            byte_sel <= 1'b0;
        else if (rd_grant)
            byte_sel <= 1'b0;
        else if (usb_valid && usb_read)
            byte_sel <= ~byte_sel;
    end

    assign usb_data   = byte_sel ? data_q[7:0] : data_q[15:8];
    assign read_error = usb_read && !usb_valid; // nothing to hand out

endmodule

/* verilog/sram_fifo_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM FIFO core top: register block, pointer logic and reader sharing
// one external 16-bit SRAM, reads taking priority over writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sram_fifo_top
    import sram_fifo_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  bus_req_t    bus,
    output logic [7:0]  bus_data_out,
    output sram_req_t   sram,
    input  logic [15:0] sram_data_in,
    input  logic        fifo_empty_in,
    input  logic [31:0] fifo_data,
    output logic        fifo_read_next,
    input  logic        usb_read,
    output logic [7:0]  usb_data,
    output logic        usb_valid,
    output logic        fifo_not_empty,
    output logic        fifo_full,
    output logic        fifo_near_full,
    output logic        fifo_read_error
);

    logic       fifo_rst;
    fifo_size_u fifo_size;
    logic       empty;
    logic       wr_req;
    logic       wr_half;
    sram_addr_t wr_addr;
    sram_addr_t rd_addr;
    logic       rd_grant;
    logic       read_error;

    sram_fifo_regs u_regs (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .bus             (bus),
        .bus_data_out    (bus_data_out),
        .fifo_size       (fifo_size),
        .read_error      (read_error),
        .fifo_rst        (fifo_rst),
        .fifo_near_full  (fifo_near_full),
        .fifo_read_error (fifo_read_error)
    );

    sram_fifo_ptrs u_ptrs (
        .BUS_CLK        (BUS_CLK),
        .fifo_rst       (fifo_rst),
        .fifo_empty_in  (fifo_empty_in),
        .rd_grant       (rd_grant),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .rd_addr        (rd_addr),
        .wr_half        (wr_half),
        .fifo_read_next (fifo_read_next),
        .empty          (empty),
        .fifo_full      (fifo_full),
        .fifo_size      (fifo_size)
    );

    sram_fifo_reader u_reader (
        .BUS_CLK      (BUS_CLK),
        .fifo_rst     (fifo_rst),
        .empty        (empty),
        .sram_data_in (sram_data_in),
        .usb_read     (usb_read),
        .rd_grant     (rd_grant),
        .usb_data     (usb_data),
        .usb_valid    (usb_valid),
        .read_error   (read_error)
    );

    // one SRAM port, read pointer owns it during rd_grant
    always_comb begin
        sram.addr = rd_grant ? rd_addr : wr_addr;
        sram.data = wr_half ? fifo_data[15:0] : fifo_data[31:16]; // high half first
        sram.we   = wr_req && !rd_grant;
        sram.oe   = rd_grant;
    end

    assign fifo_not_empty = !empty;

endmodule

/* verif/tb_clkgen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset: 8 ns BUS_CLK, RST held for 8 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clkgen (
    output logic BUS_CLK,
    output logic RST
);

    initial begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    initial begin
        RST = 1'b1;
        repeat (8) @(posedge BUS_CLK);
        #1;
        RST = 1'b0; // released off the edge like other inputs
    end

endmodule

/* verif/sram_model.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral 16-bit SRAM, synchronous write and combinational read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_fifo_params.svh"

module sram_model
    import sram_fifo_pkg::*;
(
    input  logic        BUS_CLK,
    input  sram_req_t   sram,
    output logic [15:0] data_out
);

    localparam int WORDS = 1 << `SRAM_ADDR_W;

    logic [15:0] mem [WORDS];

    initial begin
        for (int a = 0; a < WORDS; a++)
            mem[a] = 16'(a) ^ 16'(a >> 16) ^ 16'h5a3c; // unwritten cells differ
    end

    always @(posedge BUS_CLK) begin
        if (sram.we)
            mem[sram.addr] <= sram.data;
    end

    assign data_out = sram.oe ? mem[sram.addr] : 16'h0000;

endmodule

/* verif/tb_sram_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the SRAM FIFO core with models of the source FIFO,
// the consumer and the register bus and a behavioral SRAM on its port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_fifo_params.svh"

module tb_sram_fifo
    import sram_fifo_pkg::*;
();

    localparam int DEPTH = `SRAM_FIFO_DEPTH;
    localparam int LIMIT = 4000;        // cycles allowed per wait
    localparam int NPAT  = 16;

    logic        BUS_CLK;
    logic        RST;
    bus_req_t    bus = '0;
    logic [7:0]  bus_data_out;
    sram_req_t   sram;
    logic [15:0] sram_data_in;
    logic        fifo_empty_in = 1'b1;
    logic [31:0] fifo_data = '0;
    logic        fifo_read_next;
    logic        usb_read = 1'b0;
    logic [7:0]  usb_data;
    logic        usb_valid;
    logic        fifo_not_empty;
    logic        fifo_full;
    logic        fifo_near_full;
    logic        fifo_read_error;

    logic [31:0] pat [NPAT];
    logic [31:0] src_q [$];
    logic [7:0]  exp_q [$];
    logic [7:0]  got_q [$];
    bit          src_en;
    bit          src_stall;
    int          cons_mode;     // 0 idle, 1 read while valid, 2 read blindly
    int          wr_cnt;
    int          rd_cnt;
    int          blind_cnt;
    int          errors;
    int          failed_tests;

    tb_clkgen u_clk (.BUS_CLK(BUS_CLK), .RST(RST));
    sram_model u_sram (.BUS_CLK(BUS_CLK), .sram(sram), .data_out(sram_data_in));
    sram_fifo_top UUT (.*);

    // source FIFO model that also counts SRAM writes and reads
    always begin
        logic pop;
        logic wr;
        logic rd;
        @(negedge BUS_CLK);
        pop = fifo_read_next;
        wr  = sram.we;
        rd  = sram.oe;
        @(posedge BUS_CLK);
        #1;
        if (wr)
            wr_cnt++;
        if (rd)
            rd_cnt++;
        if (pop && src_q.size() > 0)
            void'(src_q.pop_front());
        fifo_empty_in = !(src_en && src_q.size() > 0) || (src_stall && $urandom % 4 == 0);
        fifo_data = (src_q.size() > 0) ? src_q[0] : 32'h0;
    end

    // consumer model takes the byte on usb_data at the next edge
    always begin
        @(posedge BUS_CLK);
        #1;
        usb_read = (cons_mode == 2) || (cons_mode == 1 && usb_valid && $urandom % 3 != 0);
        if (usb_read && usb_valid)
            got_q.push_back(usb_data);
        if (usb_read && !usb_valid)
            blind_cnt++;
    end

    task automatic report_err(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic end_test(input string name, input int mark);
        if (errors != mark)
            failed_tests++;
        $display("test %s done, %0d errors", name, errors - mark);
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        #1;
        bus = '{addr: addr, data: data, rd: 1'b0, wr: 1'b1};
        @(posedge BUS_CLK);
        #1;
        bus.wr = 1'b0;
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        #1;
        bus = '{addr: addr, data: 8'h00, rd: 1'b1, wr: 1'b0};
        @(posedge BUS_CLK);
        #1;
        bus.rd = 1'b0;
        data = bus_data_out;
        @(negedge BUS_CLK);
    endtask

    task automatic read_size(output int size);
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;
        reg_read(16'd1, b2);
        reg_read(16'd2, b1);
        reg_read(16'd3, b0);
        size = int'({b2, b1, b0});
    endtask

    // until the SRAM bus has been idle for 4 cycles
    task automatic settle();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 4) begin
            @(negedge BUS_CLK);
            quiet = (sram.we || sram.oe) ? 0 : quiet + 1;
            n++;
            if (n > LIMIT)
                fail_timeout("an idle SRAM bus");
        end
    endtask

    // runs the source or the consumer until the ring level passes target
    task automatic move_fill(input int target);
        int n;
        n = 0;
        src_en = (wr_cnt - rd_cnt) < target;
        cons_mode = src_en ? 0 : 1;
        while (src_en ? (wr_cnt - rd_cnt < target) : (wr_cnt - rd_cnt > target)) begin
            @(negedge BUS_CLK);
            n++;
            if (n > LIMIT)
                fail_timeout("the ring level target");
        end
        src_en = 1'b0;
        cons_mode = 0;
        settle();
    endtask

    task automatic check_level(inout bit exp_nf);
        int size;
        read_size(size);
        if (size != wr_cnt - rd_cnt)
            report_err("fifo_size", size, wr_cnt - rd_cnt);
        if (size >= int'(pat[2]))
            exp_nf = 1'b1;
        else if (size <= int'(pat[3]) || size == 0)
            exp_nf = 1'b0;
        if (fifo_near_full != exp_nf)
            report_err("fifo_near_full", 32'(fifo_near_full), 32'(exp_nf));
    endtask

    task automatic check_stream(input int from);
        for (int i = from; i < got_q.size(); i++) begin
            if (got_q[i] != exp_q[i])
                report_err($sformatf("usb_data byte %0d", i), 32'(got_q[i]), 32'(exp_q[i]));
        end
    endtask

    initial begin
        logic [7:0] rdata;
        int         size;
        int         n;
        int         mark;
        int         checked;
        int         blind_base;
        bit         exp_nf;
        int         steps [9];
        steps = '{40, 30, 16, 4, 0, 20, 40, 50, DEPTH - 1};
        void'($urandom(1684));
        $readmemh("verif/sram_fifo_patterns.txt", pat);
        n = 0;
        while (RST) begin
            @(negedge BUS_CLK);
            n++;
            if (n > LIMIT)
                fail_timeout("reset release");
        end

        mark = errors;
        for (int a = 1; a <= 4; a++) begin
            reg_read(16'(a), rdata);
            if (rdata != 8'h00)
                report_err($sformatf("register %0d", a), 32'(rdata), 0);
        end
        if ({fifo_not_empty, fifo_full, fifo_near_full, fifo_read_error,
             usb_valid, fifo_read_next, sram.we, sram.oe} != 8'h00)
            report_err("status {not_empty,full,near_full,read_error,usb_valid,read_next,we,oe}",
                       32'({fifo_not_empty, fifo_full, fifo_near_full, fifo_read_error,
                            usb_valid, fifo_read_next, sram.we, sram.oe}), 0);
        end_test("reset defaults", mark);

        mark = errors;
        for (int i = 4; i < NPAT; i++) begin
            src_q.push_back(pat[i]);
            for (int b = 3; b >= 0; b--)
                exp_q.push_back(pat[i][8*b +: 8]);
        end
        src_stall = 1'b1;
        src_en = 1'b1;
        cons_mode = 1;
        n = 0;
        while (got_q.size() < exp_q.size()) begin
            @(negedge BUS_CLK);
            n++;
            if (n > LIMIT)
                fail_timeout("the streamed bytes");
        end
        src_en = 1'b0;
        src_stall = 1'b0;
        cons_mode = 0;
        check_stream(0);
        checked = got_q.size();
        end_test("ordered streaming", mark);

        mark = errors;
        for (int i = 0; i < 72; i++) begin
            src_q.push_back($urandom);
            for (int b = 3; b >= 0; b--)
                exp_q.push_back(src_q[$][8*b +: 8]);
        end
        src_en = 1'b1;
        n = 0;
        while (!fifo_full) begin
            @(negedge BUS_CLK);
            n++;
            if (n > LIMIT)
                fail_timeout("fifo_full");
        end
        for (int i = 0; i < 16; i++) begin
            @(negedge BUS_CLK);
            if (fifo_read_next)
                report_err("fifo_read_next while full", 1, 0);
        end
        src_en = 1'b0;
        settle();
        read_size(size);
        if (size != DEPTH - 1)
            report_err("fifo_size", size, DEPTH - 1);
        if (!fifo_full)
            report_err("fifo_full", 0, 1);
        end_test("full back-pressure", mark);

        mark = errors;
        reg_write(16'd1, pat[0][7:0]);
        reg_write(16'd2, pat[1][7:0]);
        exp_nf = 1'b0;
        settle();
        check_level(exp_nf);
        foreach (steps[i]) begin
            move_fill(steps[i]);
            check_level(exp_nf);
        end
        check_stream(checked);
        checked = got_q.size();
        end_test("near-full hysteresis", mark);

        mark = errors;
        cons_mode = 1;
        n = 0;
        while (wr_cnt != rd_cnt || usb_valid) begin
            @(negedge BUS_CLK);
            n++;
            if (n > LIMIT)
                fail_timeout("the ring to drain");
        end
        cons_mode = 0;
        settle();
        check_stream(checked);
        blind_base = blind_cnt;
        cons_mode = 2;
        n = 0;
        while (blind_cnt - blind_base < 5) begin
            @(negedge BUS_CLK);
            n++;
            if (n > LIMIT)
                fail_timeout("reads with no byte available");
        end
        cons_mode = 0;
        settle();
        reg_read(16'd4, rdata);
        if (rdata != 8'(blind_cnt - blind_base))
            report_err("error count", 32'(rdata), blind_cnt - blind_base);
        if (!fifo_read_error)
            report_err("fifo_read_error", 0, 1);
        move_fill(10);
        if (!fifo_not_empty)
            report_err("fifo_not_empty", 0, 1);
        reg_write(16'd0, 8'h00);        // soft reset
        settle();
        read_size(size);
        if (size != 0)
            report_err("fifo_size after soft reset", size, 0);
        reg_read(16'd4, rdata);
        if (rdata != 8'h00)
            report_err("error count after soft reset", 32'(rdata), 0);
        if ({fifo_not_empty, usb_valid, fifo_read_error, fifo_near_full} != 4'h0)
            report_err("status {not_empty,usb_valid,read_error,near_full}",
                       32'({fifo_not_empty, usb_valid, fifo_read_error, fifo_near_full}), 0);
        end_test("read errors, soft reset", mark);

        $display("tests run 5, tests failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/sram_fifo_pkg.sv
verilog/sram_fifo_regs.sv
verilog/sram_fifo_ptrs.sv
verilog/sram_fifo_reader.sv
verilog/sram_fifo_top.sv
verif/tb_clkgen.sv
verif/sram_model.sv
verif/tb_sram_fifo.sv

/* run_sim.sh */
#!/bin/sh
# build the SRAM FIFO testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sram_fifo \
    -f sources.f -o tb_sram_fifo

out=$(./obj_dir/tb_sram_fifo)
echo "$out"

# exit status is the result of the search
echo "$out" | grep -q "TB PASSED"

/* verif/sram_fifo_patterns.txt */
// words 0..3: full threshold, empty threshold (1/256 steps), expected set and clear levels
// words 4..15: source FIFO words, consumed as bytes from the most significant end
000000bf
0000003f
00000030
00000010
01234567
89abcdef
deadbeef
00ff00ff
ff00ff00
a5a55a5a
13579bdf
2468ace0
80000001
7ffffffe
c3c3c3c3
0f1e2d3c
